// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_lru_table.sv
      - source/icache_tag_mem.sv
      - source/icache_lru.sv
      - source/icache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_mem_model.sv
      - bench/tb_icache.sv

// File: bench/icache_tests.txt
# op addr(hex) pmp_x miss, where miss 1 means one memory request is expected
# flush lines ignore the last two columns, flush address bit 0 set means flush all
fetch 00000000 1 1
fetch 00000004 1 0
fetch 00000010 1 1
fetch 00000018 1 0
fetch 00000100 1 1
fetch 00000200 1 1
fetch 00000300 1 1
fetch 00000004 1 0
fetch 00000400 1 1
fetch 00000008 1 0
fetch 00000104 1 1
fetch 00000304 1 0
fetch 00000200 1 1
fetch 00000408 1 1
fetch 0000000c 1 1
fetch 80000020 1 1
fetch 80000020 1 1
fetch 00000050 0 0
fetch 00000050 1 1
fetch e0000040 1 1
fetch e0000040 1 1
flush 00000200 0 0
fetch 00000204 1 1
fetch 00000000 1 0
fetch 00000400 1 0
fetch 00000010 1 0
flush 00000001 0 0
fetch 00000008 1 1
fetch 0000001c 1 1
fetch 00000058 1 1
fetch 00000404 1 1
fetch 0000040c 1 0

// File: bench/tb_icache.sv
// Testbench top for the instruction cache with file-driven tests, compare tasks and watchdog
`timescale 1ns/10ps
`include "icache_macros.svh"

module tb_icache;

    localparam int    HALF_PERIOD  = 50;
    localparam int    SEED         = 32'h536;
    localparam int    LINE_LOW     = `ICACHE_LOG2_LINE_BYTES;
    localparam int    SWEEP_CYCLES = 2 * `ICACHE_WAYS * `ICACHE_SETS;
    localparam int    TEST_CYCLES  = 200;
    localparam string TEST_FILE    = "bench/icache_tests.txt";

    // One line of the test file
    typedef struct packed {
        logic        is_flush;
        logic [31:0] addr;
        logic        pmp_x;
        logic        miss;      // One memory request expected
    } test_t;

    logic                         i_clk = 1'b0;
    logic                         i_nrst;
    logic                         i_req_valid;
    logic [`ICACHE_ADDR_BITS-1:0] i_req_addr;
    logic                         o_req_ready;
    logic                         o_resp_valid;
    icache_pkg::fetch_resp_t      o_resp;
    logic                         i_resp_ready;
    logic                         o_mem_req_valid;
    icache_pkg::mem_req_t         o_mem_req;
    logic                         i_mem_req_ready;
    logic                         i_mem_resp_valid;
    icache_pkg::mem_resp_t        i_mem_resp;
    logic [`ICACHE_ADDR_BITS-1:0] o_mpu_addr;
    logic                         i_pma_cached;
    logic                         i_pmp_x;
    logic                         i_flush_valid;
    logic [`ICACHE_ADDR_BITS-1:0] i_flush_addr;

    int                           mem_req_count;
    icache_pkg::mem_req_t         mem_last_req;
    test_t                        tests[$];
    int                           num_tests = 0;
    int                           cur_test  = -1;
    integer                       seed;

    icache_top dut0 (.*);

    tb_mem_model #(.SEED(SEED)) mem0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (o_mem_req_valid),
        .i_req        (o_mem_req),
        .o_req_ready  (i_mem_req_ready),
        .o_resp_valid (i_mem_resp_valid),
        .o_resp       (i_mem_resp),
        .o_req_count  (mem_req_count),
        .o_last_req   (mem_last_req)
    );

    always #(HALF_PERIOD) i_clk = ~i_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_resp(input icache_pkg::fetch_resp_t got,
                              input icache_pkg::fetch_resp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch o_resp in test %0d: got %h expected %h",
                                     cur_test, got, exp));
        end
    endtask

    task automatic check_mem_req(input icache_pkg::mem_req_t got,
                                 input icache_pkg::mem_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch o_mem_req in test %0d: got %h expected %h",
                                     cur_test, got, exp));
        end
    endtask

    task automatic check_mpu_addr(input logic [`ICACHE_ADDR_BITS-1:0] got,
                                  input logic [`ICACHE_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch o_mpu_addr in test %0d: got %h expected %h",
                                     cur_test, got, exp));
        end
    endtask

    task automatic check_miss(input int seen, input logic miss);
        if (seen != int'(miss)) begin
            report_failure($sformatf("Mismatch mem_req_count in test %0d: got %h expected %h",
                                     cur_test, seen, miss));
        end
    endtask

    // Each word reads as its own address xor C0DE0000
    function automatic icache_pkg::fetch_resp_t resp_for(input logic [31:0] addr,
                                                          input logic pmp_x);
        icache_pkg::fetch_resp_t resp;
        resp.addr       = addr;
        resp.data       = {addr[31:2], 2'b00} ^ 32'hC0DE_0000;
        resp.load_fault = 1'b0;
        if (!pmp_x) begin
            resp.data       = '1;
            resp.load_fault = 1'b1;
        end else if (addr[31:28] == 4'hE) begin
            resp.data       = '0;       // Faulted reads carry no data
            resp.load_fault = 1'b1;
        end
        return resp;
    endfunction

    function automatic icache_pkg::mem_req_t req_for(input logic [31:0] addr);
        icache_pkg::mem_req_t req;
        req.cached = !addr[31];
        req.addr   = req.cached ? {addr[31:LINE_LOW], {LINE_LOW{1'b0}}} : {addr[31:2], 2'b00};
        return req;
    endfunction

    function automatic logic draw_ready();
        return ($random(seed) & 3) != 0;    // Ready in about three cycles of four
    endfunction

    task automatic load_tests();
        int             fd;
        int             code;
        int             ch;
        int             pmp_x;
        int             miss;
        logic [63:0]    op;
        logic [31:0]    addr;
        test_t          t;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            report_failure("Could not open the test file");
        end
        code = $fscanf(fd, "%s", op);
        while (code == 1) begin
            if (op == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %d %d", addr, pmp_x, miss);
                if (code != 3 || (op != "fetch" && op != "flush")) begin
                    report_failure("Test file holds a line that cannot be read");
                end
                t.is_flush = (op == "flush");
                t.addr     = addr;
                t.pmp_x    = pmp_x[0];
                t.miss     = miss[0];
                tests.push_back(t);
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            report_failure("No test lines were found in the test file");
        end
        num_tests = tests.size();
    endtask

    task automatic check_sweep();
        int low_cycles;
        low_cycles = 0;
        @(negedge i_clk);
        while (!o_req_ready) begin
            if (o_resp_valid || o_mem_req_valid) begin
                report_failure("Response or memory request seen during the reset sweep");
            end
            low_cycles++;
            @(negedge i_clk);
        end
        if (low_cycles != SWEEP_CYCLES) begin
            report_failure($sformatf("Mismatch o_req_ready low cycles: got %h expected %h",
                                     low_cycles, SWEEP_CYCLES));
        end
    endtask

    // Check the held response each cycle until it is taken
    task automatic wait_response(input icache_pkg::fetch_resp_t exp, input logic hit);
        icache_pkg::fetch_resp_t held;
        @(negedge i_clk);
        if (hit && !o_resp_valid) begin
            report_failure("Hit was not answered in the cycle after acceptance");
        end
        while (!o_resp_valid) begin
            @(negedge i_clk);
        end
        check_resp(o_resp, exp);
        held = o_resp;
        while (!i_resp_ready) begin
            @(posedge i_clk);
            #1;
            i_resp_ready = draw_ready();
            @(negedge i_clk);
            if (!o_resp_valid) begin
                report_failure("o_resp_valid dropped before the response was taken");
            end
            check_resp(o_resp, held);
        end
    endtask

    task automatic issue_fetch(input test_t t);
        @(posedge i_clk);
        #1;
        i_req_valid  = 1'b1;
        i_req_addr   = t.addr;
        i_pmp_x      = t.pmp_x;
        i_pma_cached = !t.addr[31];     // Upper half of the address space is uncached
        i_resp_ready = draw_ready();
        @(negedge i_clk);
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
        wait_response(resp_for(t.addr, t.pmp_x), t.pmp_x && !t.miss);
        check_mpu_addr(o_mpu_addr, t.addr);
    endtask

    task automatic apply_flush(input logic [31:0] addr);
        @(posedge i_clk);
        #1;
        i_flush_valid = 1'b1;
        i_flush_addr  = addr;
        @(posedge i_clk);
        #1;
        i_flush_valid = 1'b0;
        @(negedge i_clk);
        if (o_req_ready) begin
            report_failure("Flush did not take the controller out of idle");
        end
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
    endtask

    initial begin : watchdog
        wait (num_tests > 0);
        repeat (5 + SWEEP_CYCLES + TEST_CYCLES * num_tests) @(posedge i_clk);
        report_failure("Timeout, the tests ran longer than their cycle budget");
    end

    initial begin
        int count_before;
        seed          = SEED;
        i_nrst        = 1'b0;
        i_req_valid   = 1'b0;
        i_req_addr    = '0;
        i_resp_ready  = 1'b0;
        i_pma_cached  = 1'b0;
        i_pmp_x       = 1'b0;
        i_flush_valid = 1'b0;
        i_flush_addr  = '0;
        load_tests();
        @(negedge i_clk);
        if (o_req_ready || o_resp_valid || o_mem_req_valid) begin
            report_failure("Handshake outputs are not low during reset");
        end
        repeat (5) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;
        check_sweep();
        foreach (tests[k]) begin
            cur_test     = k;
            count_before = mem_req_count;
            if (tests[k].is_flush) begin
                apply_flush(tests[k].addr);
                check_miss(mem_req_count - count_before, 1'b0);
            end else begin
                issue_fetch(tests[k]);
                check_miss(mem_req_count - count_before, tests[k].miss);
                if (tests[k].miss) begin
                    check_mem_req(mem_last_req, req_for(tests[k].addr));
                end
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_icache

// File: bench/tb_mem_model.sv
// Memory responder with random latency, address-based data and a load fault region
`timescale 1ns/10ps
`include "icache_macros.svh"

module tb_mem_model #(
    parameter int SEED = 32'h536
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_req_valid,
    input  icache_pkg::mem_req_t  i_req,
    output logic                  o_req_ready,
    output logic                  o_resp_valid,
    output icache_pkg::mem_resp_t o_resp,
    output int                    o_req_count,
    output icache_pkg::mem_req_t  o_last_req
);

    localparam int WORDS = `ICACHE_LINE_BITS / 32;

    integer seed;

    // Each word holds its own address xor C0DE0000
    function automatic icache_pkg::mem_resp_t read_data(input icache_pkg::mem_req_t req);
        icache_pkg::mem_resp_t resp;
        resp = '0;
        if (req.addr[31:28] == 4'hE) begin
            resp.load_fault = 1'b1;                 // Fault region, no data
        end else if (req.cached) begin
            for (int i = 0; i < WORDS; i++) begin
                resp.data[32*i +: 32] = (req.addr + 32'(4 * i)) ^ 32'hC0DE_0000;
            end
        end else begin
            resp.data[31:0] = req.addr ^ 32'hC0DE_0000;
        end
        return resp;
    endfunction

    initial begin
        int latency;
        seed         = SEED;
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_resp       = '0;
        o_req_count  = 0;
        o_last_req   = '0;
        wait (i_nrst);
        @(posedge i_clk);
        #1;
        o_req_ready = 1'b1;
        forever begin
            @(negedge i_clk);
            if (i_req_valid && o_req_ready) begin
                o_last_req  = i_req;
                o_req_count = o_req_count + 1;
                latency     = 1 + ($unsigned($random(seed)) % 8);
                @(posedge i_clk);                   // Grant taken here
                #1;
                o_req_ready = 1'b0;
                repeat (latency) @(posedge i_clk);
                #1;
                o_resp_valid = 1'b1;
                o_resp       = read_data(o_last_req);
                @(posedge i_clk);
                #1;
                o_resp_valid = 1'b0;
                o_resp       = '0;
                o_req_ready  = 1'b1;
            end
        end
    end

endmodule : tb_mem_model

// File: sim.f
+incdir+source
source/icache_pkg.sv
source/icache_lru_table.sv
source/icache_tag_mem.sv
source/icache_lru.sv
source/icache_top.sv
bench/tb_mem_model.sv
bench/tb_icache.sv

// File: source/icache_lru.sv
// Instruction cache controller FSM with hit, miss, uncached, fault, flush and reset sweep
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_lru (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_req_valid,
    input  logic [`ICACHE_ADDR_BITS-1:0]   i_req_addr,
    output logic                           o_req_ready,
    output logic                           o_resp_valid,
    output icache_pkg::fetch_resp_t        o_resp,
    input  logic                           i_resp_ready,
    output logic                           o_mem_req_valid,
    output icache_pkg::mem_req_t           o_mem_req,
    input  logic                           i_mem_req_ready,
    input  logic                           i_mem_resp_valid,
    input  icache_pkg::mem_resp_t          i_mem_resp,
    output logic [`ICACHE_ADDR_BITS-1:0]   o_mpu_addr,
    input  logic                           i_pma_cached,
    input  logic                           i_pmp_x,
    input  logic                           i_flush_valid,
    input  logic [`ICACHE_ADDR_BITS-1:0]   i_flush_addr
);

    localparam int ADDR_W   = `ICACHE_ADDR_BITS;
    localparam int LINE_LOW = `ICACHE_LOG2_LINE_BYTES;
    localparam int WAY_W    = `ICACHE_LOG2_WAYS;
    localparam int CNT_W    = `ICACHE_LOG2_WAYS + `ICACHE_LOG2_SETS;

    typedef enum logic [3:0] {
        ST_IDLE, ST_CHECK_HIT, ST_TRANSLATE, ST_WAIT_GRANT, ST_WAIT_RESP, ST_CHECK_RESP,
        ST_SETUP_READ, ST_FLUSH_ADDR, ST_FLUSH_CHECK, ST_RESET, ST_RESET_WRITE
    } state_t;

    typedef struct packed {
        state_t               state;
        logic [ADDR_W-1:0]    req_addr;
        logic                 mem_req_valid;
        icache_pkg::mem_req_t mem_req;
        logic                 load_fault;
        logic                 flush_pend;
        logic                 flush_all;
        logic [ADDR_W-1:0]    flush_addr;
        logic [CNT_W-1:0]     cnt;                  // Lines left in a walk
    } ctrl_t;

    // Power-up starts a full sweep from line 0
    localparam ctrl_t CTRL_RESET = '{
        state: ST_RESET, req_addr: '0, mem_req_valid: 1'b0, mem_req: '0, load_fault: 1'b0,
        flush_pend: 1'b0, flush_all: 1'b0, flush_addr: '0, cnt: '1
    };

    ctrl_t                        r, rin;
    logic [`ICACHE_LINE_BITS-1:0] line_q, line_d;   // Captured memory data
    icache_pkg::line_cmd_t        line_cmd;
    icache_pkg::line_rd_t         line_rd;

    icache_tag_mem u_tag_mem (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_cmd  (line_cmd),
        .o_rd   (line_rd)
    );

    always_comb begin
        logic                    ready_next;
        logic [ADDR_W-1:0]       addr_direct_next;
        logic [LINE_LOW-3:0]     word_sel;

        rin        = r;
        line_d     = line_q;
        ready_next = 1'b0;
        word_sel   = r.req_addr[LINE_LOW-1:2];

        line_cmd.re         = 1'b0;
        line_cmd.we         = 1'b0;
        line_cmd.direct     = 1'b0;
        line_cmd.invalidate = 1'b0;
        line_cmd.addr       = r.req_addr;
        line_cmd.wdata      = line_q;

        o_req_ready       = 1'b0;
        o_resp_valid      = 1'b0;
        o_resp.addr       = r.req_addr;
        o_resp.data       = line_rd.data[32*word_sel +: 32];
        o_resp.load_fault = 1'b0;

        // Walk order: ways of a set first, then the next set
        if (&r.req_addr[WAY_W-1:0]) begin
            addr_direct_next = {r.req_addr[ADDR_W-1:LINE_LOW] + 1'b1, {LINE_LOW{1'b0}}};
        end else begin
            addr_direct_next = r.req_addr + 1'b1;
        end

        case (r.state)
            ST_IDLE: begin
                ready_next = 1'b1;
            end
            ST_CHECK_HIT: begin
                if (line_rd.hit && line_rd.valid) begin
                    o_resp_valid = 1'b1;
                    if (i_resp_ready) begin
                        ready_next = 1'b1;
                        rin.state  = ST_IDLE;
                    end
                end else begin
                    rin.state = ST_TRANSLATE;
                end
            end
            ST_TRANSLATE: begin
                if (!i_pmp_x) begin
                    line_d         = '1;            // No execute right, answer all ones
                    rin.load_fault = 1'b1;
                    rin.state      = ST_CHECK_RESP;
                end else begin
                    rin.load_fault     = 1'b0;
                    rin.mem_req_valid  = 1'b1;
                    rin.mem_req.cached = i_pma_cached;
                    if (i_pma_cached) begin
                        rin.mem_req.addr = {r.req_addr[ADDR_W-1:LINE_LOW], {LINE_LOW{1'b0}}};
                    end else begin
                        rin.mem_req.addr = {r.req_addr[ADDR_W-1:2], 2'b00};
                    end
                    rin.state = ST_WAIT_GRANT;
                end
            end
            ST_WAIT_GRANT: begin
                if (i_mem_req_ready) begin
                    rin.mem_req_valid = 1'b0;
                    rin.state         = ST_WAIT_RESP;
                end
            end
            ST_WAIT_RESP: begin
                if (i_mem_resp_valid) begin
                    line_d         = i_mem_resp.data;
                    rin.load_fault = i_mem_resp.load_fault;
                    rin.state      = ST_CHECK_RESP;
                end
            end
            ST_CHECK_RESP: begin
                if (!r.mem_req.cached || r.load_fault) begin
                    // Answer straight from the captured data, nothing is cached
                    o_resp_valid      = 1'b1;
                    o_resp.data       = r.mem_req.cached ? line_q[32*word_sel +: 32]
                                                         : line_q[31:0];
                    o_resp.load_fault = r.load_fault;
                    if (i_resp_ready) begin
                        rin.state = ST_IDLE;
                    end
                end else begin
                    line_cmd.we = 1'b1;             // Fill into the LRU victim
                    rin.state   = ST_SETUP_READ;
                end
            end
            ST_SETUP_READ: begin
                line_cmd.re = 1'b1;                 // Reread so the hit path answers
                rin.state   = ST_CHECK_HIT;
            end
            ST_FLUSH_ADDR: begin
                line_cmd.we         = 1'b1;
                line_cmd.invalidate = 1'b1;
                line_cmd.direct     = r.flush_all;
                rin.state           = ST_FLUSH_CHECK;
            end
            ST_FLUSH_CHECK: begin
                if (|r.cnt) begin
                    rin.cnt      = r.cnt - 1'b1;
                    rin.req_addr = addr_direct_next;
                    rin.state    = ST_FLUSH_ADDR;
                end else begin
                    rin.state = ST_IDLE;
                end
            end
            ST_RESET: begin
                rin.flush_pend = 1'b0;              // Sweep cleans everything anyway
                rin.state      = ST_RESET_WRITE;
            end
            ST_RESET_WRITE: begin
                line_cmd.we         = 1'b1;
                line_cmd.invalidate = 1'b1;
                line_cmd.direct     = 1'b1;
                if (|r.cnt) begin
                    rin.cnt      = r.cnt - 1'b1;
                    rin.req_addr = addr_direct_next;
                    rin.state    = ST_RESET;
                end else begin
                    rin.state = ST_IDLE;
                end
            end
            default: begin
                rin.state = ST_IDLE;
            end
        endcase

        // Pending flush goes ahead of a waiting fetch
        if (ready_next) begin
            if (r.flush_pend) begin
                rin.flush_pend = 1'b0;
                rin.state      = ST_FLUSH_ADDR;
                rin.req_addr   = r.flush_all ? '0
                               : {r.flush_addr[ADDR_W-1:LINE_LOW], {LINE_LOW{1'b0}}};
                rin.cnt        = r.flush_all ? '1 : '0;
            end else begin
                o_req_ready   = 1'b1;
                line_cmd.re   = i_req_valid;
                line_cmd.addr = i_req_addr;
                if (i_req_valid) begin
                    rin.req_addr = i_req_addr;
                    rin.state    = ST_CHECK_HIT;
                end
            end
        end

        if (i_flush_valid) begin
            rin.flush_pend = 1'b1;
            rin.flush_all  = i_flush_addr[0];     // Bit 0 selects flush-all
            rin.flush_addr = i_flush_addr;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= CTRL_RESET;
        end else begin
            r <= rin;
        end
    end

    always_ff @(posedge i_clk) begin
        line_q <= line_d;
    end

    assign o_mem_req_valid = r.mem_req_valid;
    assign o_mem_req       = r.mem_req;
    assign o_mpu_addr      = r.req_addr;

endmodule : icache_lru

// File: source/icache_lru_table.sv
// Per-set LRU order storage with access update and victim selection
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_lru_table (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic [`ICACHE_LOG2_SETS-1:0] i_set,
    input  logic                         i_access,
    input  logic [`ICACHE_LOG2_WAYS-1:0] i_way,
    output logic [`ICACHE_LOG2_WAYS-1:0] o_victim
);

    localparam int WAYS  = `ICACHE_WAYS;
    localparam int WAY_W = `ICACHE_LOG2_WAYS;

    // Slot 0 is the most recent way, the last slot the oldest
    logic [WAYS-1:0][WAY_W-1:0] order_q [`ICACHE_SETS];
    logic [WAYS-1:0][WAY_W-1:0] order_d;

    // Move the accessed way to the front, shift the younger ones back
    always_comb begin
        logic seen;

        seen       = 1'b0;
        order_d[0] = i_way;
        for (int i = 1; i < WAYS; i++) begin
            if (order_q[i_set][i-1] == i_way) begin
                seen = 1'b1;
            end
            order_d[i] = seen ? order_q[i_set][i] : order_q[i_set][i-1];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int i = 0; i < WAYS; i++) begin
                    order_q[s][i] <= WAY_W'(i);     // Way 0 newest, way 3 oldest
                end
            end
        end else if (i_access) begin
            order_q[i_set] <= order_d;
        end
    end

    assign o_victim = order_q[i_set][WAYS-1];

endmodule : icache_lru_table

// File: source/icache_macros.svh
// Address width and cache geometry constants for the instruction cache
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Fetch address width
`define ICACHE_ADDR_BITS        32

// 16-byte lines
`define ICACHE_LOG2_LINE_BYTES  4
`define ICACHE_LINE_BITS        128

// Four ways
`define ICACHE_LOG2_WAYS        2
`define ICACHE_WAYS             (1 << `ICACHE_LOG2_WAYS)

// Sixteen sets per way
`define ICACHE_LOG2_SETS        4
`define ICACHE_SETS             (1 << `ICACHE_LOG2_SETS)

`endif

// File: source/icache_pkg.sv
// Packed struct types for fetch responses, memory requests and tag memory access
`include "icache_macros.svh"

package icache_pkg;

    // One answer on the fetch port
    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic [31:0]                  data;         // Aligned instruction word
        logic                         load_fault;
    } fetch_resp_t;

    // Read request towards memory
    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic                         cached;       // Full line when set, one word otherwise
    } mem_req_t;

    // Memory answer, uncached word in the low 32 bits
    typedef struct packed {
        logic [`ICACHE_LINE_BITS-1:0] data;
        logic                         load_fault;
    } mem_resp_t;

    // Controller to tag memory, one command per cycle
    typedef struct packed {
        logic                         re;
        logic                         we;
        logic                         direct;       // Way taken from the low address bits
        logic                         invalidate;
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic [`ICACHE_LINE_BITS-1:0] wdata;
    } line_cmd_t;

    // Registered lookup result
    typedef struct packed {
        logic                         hit;
        logic [`ICACHE_LINE_BITS-1:0] data;
        logic                         valid;
    } line_rd_t;

endpackage : icache_pkg

// File: source/icache_tag_mem.sv
// Way-coupled tag, valid flag and line arrays with registered lookup and way choice
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tag_mem (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  icache_pkg::line_cmd_t i_cmd,
    output icache_pkg::line_rd_t  o_rd
);

    localparam int WAYS     = `ICACHE_WAYS;
    localparam int SETS     = `ICACHE_SETS;
    localparam int WAY_W    = `ICACHE_LOG2_WAYS;
    localparam int SET_W    = `ICACHE_LOG2_SETS;
    localparam int LINE_LOW = `ICACHE_LOG2_LINE_BYTES;
    localparam int TAG_W    = `ICACHE_ADDR_BITS - SET_W - LINE_LOW;

    logic [TAG_W-1:0]             tag_mem  [WAYS][SETS];
    logic [`ICACHE_LINE_BITS-1:0] line_mem [WAYS][SETS];
    logic [SETS-1:0]              valid_q  [WAYS];

    logic [SET_W-1:0]             set_idx;
    logic [TAG_W-1:0]             addr_tag;
    logic [WAYS-1:0]              match;
    logic                         hit;
    logic [WAY_W-1:0]             hit_way;
    logic [WAY_W-1:0]             victim;
    logic [WAY_W-1:0]             pick_way;
    logic [WAY_W-1:0]             wr_way;
    logic                         wr_en;
    logic                         fill;

    logic                         rd_hit_q;
    logic                         rd_valid_q;
    logic [`ICACHE_LINE_BITS-1:0] rd_data_q;

    assign set_idx  = i_cmd.addr[LINE_LOW +: SET_W];
    assign addr_tag = i_cmd.addr[`ICACHE_ADDR_BITS-1 -: TAG_W];

    // Compare all ways of the set at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[w][set_idx] && (tag_mem[w][set_idx] == addr_tag);
            if (match[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit      = |match;
    assign pick_way = hit ? hit_way : victim;
    assign wr_way   = i_cmd.direct ? i_cmd.addr[WAY_W-1:0] : pick_way;

    // A plain invalidate only touches a line that is present
    assign wr_en = i_cmd.we && (i_cmd.direct || !i_cmd.invalidate || hit);
    assign fill  = i_cmd.we && !i_cmd.invalidate && !i_cmd.direct;

    icache_lru_table u_lru (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_set    (set_idx),
        .i_access ((i_cmd.re && hit) || fill),
        .i_way    (fill ? wr_way : hit_way),
        .o_victim (victim)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
            rd_hit_q   <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_way][set_idx] <= !i_cmd.invalidate;
            end
            if (i_cmd.re) begin
                rd_hit_q   <= hit;
                rd_valid_q <= valid_q[pick_way][set_idx];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && !i_cmd.invalidate) begin
            tag_mem[wr_way][set_idx]  <= addr_tag;
            line_mem[wr_way][set_idx] <= i_cmd.wdata;
        end
        if (i_cmd.re) begin
            rd_data_q <= line_mem[pick_way][set_idx];   // Hit way, or victim on a miss
        end
    end

    always_comb begin
        o_rd.hit   = rd_hit_q;
        o_rd.data  = rd_data_q;
        o_rd.valid = rd_valid_q;
    end

endmodule : icache_tag_mem

// File: source/icache_top.sv
// Instruction cache top level with fetch, memory, MPU and flush ports
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_top (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_req_valid,
    input  logic [`ICACHE_ADDR_BITS-1:0]   i_req_addr,
    output logic                           o_req_ready,
    output logic                           o_resp_valid,
    output icache_pkg::fetch_resp_t        o_resp,
    input  logic                           i_resp_ready,
    output logic                           o_mem_req_valid,
    output icache_pkg::mem_req_t           o_mem_req,
    input  logic                           i_mem_req_ready,
    input  logic                           i_mem_resp_valid,
    input  icache_pkg::mem_resp_t          i_mem_resp,
    output logic [`ICACHE_ADDR_BITS-1:0]   o_mpu_addr,
    input  logic                           i_pma_cached,
    input  logic                           i_pmp_x,
    input  logic                           i_flush_valid,
    input  logic [`ICACHE_ADDR_BITS-1:0]   i_flush_addr
);

    // Controller holds the tag memory and LRU table below it
    icache_lru u_ctrl (.*);

endmodule : icache_top
